// ==== Bender.yml ====
package:
  name: cpu_control_unit

sources:
  - src/cpu_ctrl_pkg.sv
  - src/ctrl_sequencer.sv
  - src/alu_op_decoder.sv
  - src/flow_decoder.sv
  - src/followup_decoder.sv
  - src/control_unit.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/control_unit_tb.sv

// ==== list.f ====
src/cpu_ctrl_pkg.sv
src/ctrl_sequencer.sv
src/alu_op_decoder.sv
src/flow_decoder.sv
src/followup_decoder.sv
src/control_unit.sv
testbench/tb_clock_gen.sv
testbench/control_unit_tb.sv

// ==== src/alu_op_decoder.sv ====
`timescale 1ns/1ps

module alu_op_decoder (
	input  cpu_ctrl_pkg::opcode_t opcode,
	output cpu_ctrl_pkg::ctrl_t   ctrl
);

	cpu_ctrl_pkg::op_group_t group;
	cpu_ctrl_pkg::reg_idx_t  ra;

	assign group = cpu_ctrl_pkg::op_group(opcode);
	assign ra    = cpu_ctrl_pkg::op_ra(opcode);

	always_comb begin
		ctrl = cpu_ctrl_pkg::CTRL_IDLE;
		case (group)
			cpu_ctrl_pkg::OPC_MOV, cpu_ctrl_pkg::OPC_ADD, cpu_ctrl_pkg::OPC_SUB,
			cpu_ctrl_pkg::OPC_AND, cpu_ctrl_pkg::OPC_OR: begin
				ctrl.regf = cpu_ctrl_pkg::regf_alu_wb(cpu_ctrl_pkg::WR_ADDR_RA);
				ctrl.alu_op = cpu_ctrl_pkg::alu_op_t'({2'b00, group}); // Codes 1 to 5
			end
			cpu_ctrl_pkg::OPC_SHIFT: begin
				case (ra)
					2'd0: begin
						ctrl.regf = cpu_ctrl_pkg::regf_alu_wb(cpu_ctrl_pkg::WR_ADDR_RB);
						ctrl.alu_op = cpu_ctrl_pkg::ALU_RLC;
					end
					2'd1: begin
						ctrl.regf = cpu_ctrl_pkg::regf_alu_wb(cpu_ctrl_pkg::WR_ADDR_RB);
						ctrl.alu_op = cpu_ctrl_pkg::ALU_RRC;
					end
					2'd2: ctrl.alu_op = cpu_ctrl_pkg::ALU_SETC; // Carry only
					default: ctrl.alu_op = cpu_ctrl_pkg::ALU_CLRC;
				endcase
			end
			cpu_ctrl_pkg::OPC_STACK: begin
				case (ra)
					2'd0: begin // PUSH rb, SP counts down
						ctrl.alu_op = cpu_ctrl_pkg::ALU_PUSH;
						ctrl.mem.we = 1'b1;
						ctrl.mem.addr_sel = cpu_ctrl_pkg::DMEM_A_SP;
						ctrl.mem.wd_sel = cpu_ctrl_pkg::DMEM_WD_RB;
						ctrl.regf.we = 1'b1;
						ctrl.regf.wr_addr_sel = cpu_ctrl_pkg::WR_ADDR_SP;
						ctrl.regf.wd_sel = cpu_ctrl_pkg::RDATA_STACK;
						ctrl.flow.sp_dir = 1'b0;
					end
					2'd1: begin // POP into rb from ++SP
						ctrl.alu_op = cpu_ctrl_pkg::ALU_POP;
						ctrl.mem.re = 1'b1;
						ctrl.mem.addr_sel = cpu_ctrl_pkg::DMEM_A_SP_INC;
						ctrl.regf.we = 1'b1;
						ctrl.regf.wr_addr_sel = cpu_ctrl_pkg::WR_ADDR_RB;
						ctrl.regf.wd_sel = cpu_ctrl_pkg::RDATA_DATA;
						ctrl.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_MEM;
						ctrl.flow.sp_dir = 1'b1;
						ctrl.flow.sp_inc = 1'b1;
					end
					2'd2: begin
						ctrl.alu_op = cpu_ctrl_pkg::ALU_OUT;
						ctrl.flow.out_port = 1'b1; // Latch rb on the port
					end
					default: begin
						ctrl.alu_op = cpu_ctrl_pkg::ALU_IN;
						ctrl.regf.we = 1'b1;
						ctrl.regf.wr_addr_sel = cpu_ctrl_pkg::WR_ADDR_RB;
						ctrl.regf.wd_sel = cpu_ctrl_pkg::RDATA_IN_PORT;
					end
				endcase
			end
			cpu_ctrl_pkg::OPC_UNARY: begin
				ctrl.regf = cpu_ctrl_pkg::regf_alu_wb(cpu_ctrl_pkg::WR_ADDR_RB);
				case (ra)
					2'd0: ctrl.alu_op = cpu_ctrl_pkg::ALU_NOT;
					2'd1: ctrl.alu_op = cpu_ctrl_pkg::ALU_NEG;
					2'd2: ctrl.alu_op = cpu_ctrl_pkg::ALU_INC;
					default: ctrl.alu_op = cpu_ctrl_pkg::ALU_DEC;
				endcase
			end
			cpu_ctrl_pkg::OPC_LDI: begin
				// rb gets memory at the address held in ra
				ctrl.alu_op = cpu_ctrl_pkg::ALU_LDI;
				ctrl.mem.re = 1'b1;
				ctrl.mem.addr_sel = cpu_ctrl_pkg::DMEM_A_ALU;
				ctrl.regf.we = 1'b1;
				ctrl.regf.wr_addr_sel = cpu_ctrl_pkg::WR_ADDR_RB;
				ctrl.regf.wd_sel = cpu_ctrl_pkg::RDATA_DATA;
				ctrl.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_MEM;
			end
			cpu_ctrl_pkg::OPC_STI: begin
				ctrl.alu_op = cpu_ctrl_pkg::ALU_STI;
				ctrl.mem.we = 1'b1;
				ctrl.mem.addr_sel = cpu_ctrl_pkg::DMEM_A_ALU; // Address from ra
				ctrl.mem.wd_sel = cpu_ctrl_pkg::DMEM_WD_RB;
			end
			default: begin
				ctrl = cpu_ctrl_pkg::CTRL_IDLE; // NOP and groups decoded elsewhere
			end
		endcase
	end

endmodule

// ==== src/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  cpu_ctrl_pkg::opcode_t  opcode,
	input  cpu_ctrl_pkg::flags_t   flags,
	output cpu_ctrl_pkg::ctrl_t    ctrl,
	output cpu_ctrl_pkg::reg_idx_t old_rb,
	output logic                   is_2byte_d,
	output logic                   two_byte
);

	cpu_ctrl_pkg::seq_state_t state;
	cpu_ctrl_pkg::opcode_t    held;
	logic                     loop_start;
	cpu_ctrl_pkg::ctrl_t      alu_ctrl;
	cpu_ctrl_pkg::ctrl_t      flow_ctrl;
	cpu_ctrl_pkg::ctrl_t      followup_ctrl;

	ctrl_sequencer u_sequencer (
		.clk        (clk),
		.rst        (rst),
		.opcode     (opcode),
		.loop_start (loop_start),
		.state      (state),
		.held       (held),
		.two_byte   (two_byte)
	);

	alu_op_decoder u_alu_dec (.opcode(opcode), .ctrl(alu_ctrl));

	flow_decoder u_flow_dec (
		.opcode     (opcode),
		.flags      (flags),
		.ctrl       (flow_ctrl),
		.loop_start (loop_start)
	);

	followup_decoder u_followup_dec (
		.state  (state),
		.held   (held),
		.ctrl   (followup_ctrl),
		.old_rb (old_rb)
	);

	assign is_2byte_d = two_byte; // Stalls fetch for the prefix cycle

	always_comb begin
		if (state != cpu_ctrl_pkg::SEQ_IDLE) begin
			ctrl = followup_ctrl;          // Opcode input ignored here
		end else if (two_byte) begin
			ctrl = cpu_ctrl_pkg::CTRL_IDLE;
		end else begin
			case (cpu_ctrl_pkg::op_group(opcode))
				cpu_ctrl_pkg::OPC_BRANCH, cpu_ctrl_pkg::OPC_LOOP,
				cpu_ctrl_pkg::OPC_JUMP: ctrl = flow_ctrl;
				default: ctrl = alu_ctrl;
			endcase
		end
	end

endmodule

// ==== src/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	typedef logic [7:0] opcode_t;   // One instruction byte
	typedef logic [3:0] op_group_t; // Major opcode field
	typedef logic [1:0] reg_idx_t;  // ra, rb or branch field
	typedef logic [3:0] flags_t;    // {V, C, N, Z}

	// Major opcodes, upper nibble of the byte
	localparam op_group_t OPC_NOP    = 4'd0;
	localparam op_group_t OPC_MOV    = 4'd1;
	localparam op_group_t OPC_ADD    = 4'd2;
	localparam op_group_t OPC_SUB    = 4'd3;
	localparam op_group_t OPC_AND    = 4'd4;
	localparam op_group_t OPC_OR     = 4'd5;
	localparam op_group_t OPC_SHIFT  = 4'd6;  // RLC, RRC, SETC, CLRC
	localparam op_group_t OPC_STACK  = 4'd7;  // PUSH, POP, OUT, IN
	localparam op_group_t OPC_UNARY  = 4'd8;  // NOT, NEG, INC, DEC
	localparam op_group_t OPC_BRANCH = 4'd9;  // JZ, JN, JC, JV
	localparam op_group_t OPC_LOOP   = 4'd10;
	localparam op_group_t OPC_JUMP   = 4'd11; // JMP, CALL, RET
	localparam op_group_t OPC_LONG   = 4'd12; // Two-byte prefix
	localparam op_group_t OPC_LDI    = 4'd13;
	localparam op_group_t OPC_STI    = 4'd14;

	localparam int FLAG_Z_BIT = 0;
	localparam int FLAG_N_BIT = 1;
	localparam int FLAG_C_BIT = 2;
	localparam int FLAG_V_BIT = 3;

	typedef enum logic [5:0] {
		ALU_NOP  = 6'd0,  ALU_MOV  = 6'd1,  ALU_ADD  = 6'd2,  ALU_SUB      = 6'd3,
		ALU_AND  = 6'd4,  ALU_OR   = 6'd5,  ALU_RLC  = 6'd6,  ALU_RRC      = 6'd7,
		ALU_SETC = 6'd8,  ALU_CLRC = 6'd9,  ALU_PUSH = 6'd10, ALU_POP      = 6'd11,
		ALU_OUT  = 6'd12, ALU_IN   = 6'd13, ALU_NOT  = 6'd14, ALU_NEG      = 6'd15,
		ALU_INC  = 6'd16, ALU_DEC  = 6'd17, ALU_JZ   = 6'd18, ALU_JN       = 6'd19,
		ALU_JC   = 6'd20, ALU_JV   = 6'd21, ALU_LOOP = 6'd22, ALU_PASS_RD2 = 6'd23,
		ALU_CALL = 6'd24, ALU_RET  = 6'd25, ALU_RTI  = 6'd26, ALU_LDM      = 6'd27,
		ALU_LDD  = 6'd28, ALU_STD  = 6'd29, ALU_LDI  = 6'd30, ALU_STI      = 6'd31
	} alu_op_t;

	typedef enum logic [1:0] {
		PC_SEL_INC  = 2'b00, // PC + 1
		PC_SEL_JUMP = 2'b11  // ALU or memory output
	} pc_sel_t;

	typedef enum logic [1:0] {
		WR_ADDR_RA = 2'b00, WR_ADDR_RB = 2'b01, WR_ADDR_SP = 2'b10, WR_ADDR_OLD_RB = 2'b11
	} wr_addr_sel_t;

	typedef enum logic [1:0] {
		RDATA_STACK = 2'b00, RDATA_IN_PORT = 2'b01, RDATA_DATA = 2'b10, RDATA_IMM = 2'b11
	} rdata_sel_t;

	typedef enum logic [1:0] {
		OUT_SEL_MEM = 2'b00, // Data memory read data
		OUT_SEL_ALU = 2'b01
	} out_sel_t;

	typedef enum logic [1:0] {
		DMEM_A_ALU = 2'b00, DMEM_A_SP = 2'b01, DMEM_A_SP_INC = 2'b10, DMEM_A_EA = 2'b11
	} dmem_addr_sel_t;

	typedef enum logic [1:0] {
		DMEM_WD_ALU = 2'b00, DMEM_WD_RB = 2'b01, DMEM_WD_PC_INC = 2'b10
	} dmem_wd_sel_t;

	typedef struct packed {
		logic         we;
		wr_addr_sel_t wr_addr_sel;
		rdata_sel_t   wd_sel;
		out_sel_t     out_sel;
		logic         rd2_sel;     // Second read port on held rb
	} regf_ctrl_t;

	typedef struct packed {
		logic           we;
		logic           re;
		dmem_addr_sel_t addr_sel;
		dmem_wd_sel_t   wd_sel;
	} mem_ctrl_t;

	typedef struct packed {
		pc_sel_t pc_sel;
		logic    branch_taken;
		logic    is_ret;
		logic    sp_dir;       // 1 counts the stack pointer up
		logic    sp_inc;
		logic    out_port;
	} flow_ctrl_t;

	typedef struct packed {
		regf_ctrl_t regf;
		mem_ctrl_t  mem;
		flow_ctrl_t flow;
		alu_op_t    alu_op;
	} ctrl_t;

	localparam ctrl_t CTRL_IDLE = '{
		regf:   '{we: 1'b0, wr_addr_sel: WR_ADDR_RA, wd_sel: RDATA_STACK,
			out_sel: OUT_SEL_MEM, rd2_sel: 1'b0},
		mem:    '{we: 1'b0, re: 1'b0, addr_sel: DMEM_A_ALU, wd_sel: DMEM_WD_ALU},
		flow:   '{pc_sel: PC_SEL_INC, branch_taken: 1'b0, is_ret: 1'b0, sp_dir: 1'b0,
			sp_inc: 1'b0, out_port: 1'b0},
		alu_op: ALU_NOP
	};

	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0, SEQ_SECOND_BYTE = 2'd1, SEQ_LOOP = 2'd2
	} seq_state_t;

	function automatic op_group_t op_group(input opcode_t op);
		return op[7:4];
	endfunction

	function automatic reg_idx_t op_ra(input opcode_t op);
		return op[3:2]; // Also the branch field
	endfunction

	function automatic reg_idx_t op_rb(input opcode_t op);
		return op[1:0];
	endfunction

	// ALU result routed into the register file at dst
	function automatic regf_ctrl_t regf_alu_wb(input wr_addr_sel_t dst);
		return '{we: 1'b1, wr_addr_sel: dst, wd_sel: RDATA_DATA,
			out_sel: OUT_SEL_ALU, rd2_sel: 1'b0};
	endfunction

endpackage

// ==== src/ctrl_sequencer.sv ====
`timescale 1ns/1ps

module ctrl_sequencer (
	input  logic                     clk,
	input  logic                     rst,
	input  cpu_ctrl_pkg::opcode_t    opcode,
	input  logic                     loop_start,
	output cpu_ctrl_pkg::seq_state_t state,
	output cpu_ctrl_pkg::opcode_t    held,
	output logic                     two_byte
);

	cpu_ctrl_pkg::seq_state_t next_state;

	// A prefix only counts when no follow-up cycle is pending
	assign two_byte = (state == cpu_ctrl_pkg::SEQ_IDLE) &&
		(cpu_ctrl_pkg::op_group(opcode) == cpu_ctrl_pkg::OPC_LONG);

	always_comb begin
		next_state = cpu_ctrl_pkg::SEQ_IDLE;
		case (state)
			cpu_ctrl_pkg::SEQ_IDLE: begin
				if (two_byte) begin
					next_state = cpu_ctrl_pkg::SEQ_SECOND_BYTE;
				end else if (loop_start) begin
					next_state = cpu_ctrl_pkg::SEQ_LOOP; // Write-back of ra next
				end
			end
			default: begin
				next_state = cpu_ctrl_pkg::SEQ_IDLE;    // Follow-up lasts one cycle
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= cpu_ctrl_pkg::SEQ_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// First byte of LDM, LDD or STD
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			held <= '0;
		end else if (two_byte) begin
			held <= opcode;
		end
	end

endmodule

// ==== src/flow_decoder.sv ====
`timescale 1ns/1ps

module flow_decoder (
	input  cpu_ctrl_pkg::opcode_t opcode,
	input  cpu_ctrl_pkg::flags_t  flags,
	output cpu_ctrl_pkg::ctrl_t   ctrl,
	output logic                  loop_start
);

	cpu_ctrl_pkg::reg_idx_t brx;
	logic                   flag_hit;
	cpu_ctrl_pkg::alu_op_t  br_op;

	assign brx = cpu_ctrl_pkg::op_ra(opcode);

	// Flag and fall-through code of each conditional branch
	always_comb begin
		case (brx)
			2'd0: begin
				flag_hit = flags[cpu_ctrl_pkg::FLAG_Z_BIT];
				br_op = cpu_ctrl_pkg::ALU_JZ;
			end
			2'd1: begin
				flag_hit = flags[cpu_ctrl_pkg::FLAG_N_BIT];
				br_op = cpu_ctrl_pkg::ALU_JN;
			end
			2'd2: begin
				flag_hit = flags[cpu_ctrl_pkg::FLAG_C_BIT];
				br_op = cpu_ctrl_pkg::ALU_JC;
			end
			default: begin
				flag_hit = flags[cpu_ctrl_pkg::FLAG_V_BIT];
				br_op = cpu_ctrl_pkg::ALU_JV;
			end
		endcase
	end

	assign loop_start = (cpu_ctrl_pkg::op_group(opcode) == cpu_ctrl_pkg::OPC_LOOP);

	always_comb begin
		ctrl = cpu_ctrl_pkg::CTRL_IDLE;
		case (cpu_ctrl_pkg::op_group(opcode))
			cpu_ctrl_pkg::OPC_BRANCH: begin
				ctrl.alu_op = br_op;
				if (flag_hit) begin
					ctrl.alu_op = cpu_ctrl_pkg::ALU_PASS_RD2; // Target is rb
					ctrl.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_ALU;
					ctrl.flow.pc_sel = cpu_ctrl_pkg::PC_SEL_JUMP;
					ctrl.flow.branch_taken = 1'b1;
				end
			end
			cpu_ctrl_pkg::OPC_LOOP: begin
				ctrl.alu_op = cpu_ctrl_pkg::ALU_LOOP; // ra - 1
				if (!flags[cpu_ctrl_pkg::FLAG_Z_BIT]) begin
					ctrl.flow.pc_sel = cpu_ctrl_pkg::PC_SEL_JUMP;
					ctrl.flow.branch_taken = 1'b1;
				end
			end
			cpu_ctrl_pkg::OPC_JUMP: begin
				case (brx)
					2'd0: begin // JMP
						ctrl.alu_op = cpu_ctrl_pkg::ALU_PASS_RD2;
						ctrl.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_ALU;
						ctrl.flow.pc_sel = cpu_ctrl_pkg::PC_SEL_JUMP;
						ctrl.flow.branch_taken = 1'b1;
					end
					2'd1: begin // CALL pushes PC + 1
						ctrl.alu_op = cpu_ctrl_pkg::ALU_CALL;
						ctrl.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_ALU;
						ctrl.flow.pc_sel = cpu_ctrl_pkg::PC_SEL_JUMP;
						ctrl.flow.branch_taken = 1'b1;
						ctrl.mem.we = 1'b1;
						ctrl.mem.addr_sel = cpu_ctrl_pkg::DMEM_A_SP;
						ctrl.mem.wd_sel = cpu_ctrl_pkg::DMEM_WD_PC_INC;
						ctrl.regf.we = 1'b1;
						ctrl.regf.wr_addr_sel = cpu_ctrl_pkg::WR_ADDR_SP;
						ctrl.regf.wd_sel = cpu_ctrl_pkg::RDATA_STACK;
						ctrl.flow.sp_dir = 1'b0;
					end
					2'd2: begin // RET
						ctrl.alu_op = cpu_ctrl_pkg::ALU_RET;
						ctrl.mem.re = 1'b1;
						ctrl.mem.addr_sel = cpu_ctrl_pkg::DMEM_A_SP;
						ctrl.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_MEM; // Return address
						ctrl.flow.pc_sel = cpu_ctrl_pkg::PC_SEL_JUMP;
						ctrl.flow.is_ret = 1'b1;
						ctrl.flow.sp_inc = 1'b1;
					end
					default: begin
						ctrl = cpu_ctrl_pkg::CTRL_IDLE;
					end
				endcase
			end
			default: begin
				ctrl = cpu_ctrl_pkg::CTRL_IDLE;
			end
		endcase
	end

endmodule

// ==== src/followup_decoder.sv ====
`timescale 1ns/1ps

module followup_decoder (
	input  cpu_ctrl_pkg::seq_state_t state,
	input  cpu_ctrl_pkg::opcode_t    held,
	output cpu_ctrl_pkg::ctrl_t      ctrl,
	output cpu_ctrl_pkg::reg_idx_t   old_rb
);

	assign old_rb = cpu_ctrl_pkg::op_rb(held);

	always_comb begin
		ctrl = cpu_ctrl_pkg::CTRL_IDLE;
		case (state)
			cpu_ctrl_pkg::SEQ_SECOND_BYTE: begin
				case (cpu_ctrl_pkg::op_ra(held))
					2'd0: begin // LDM
						ctrl.alu_op = cpu_ctrl_pkg::ALU_LDM;
						ctrl.regf.we = 1'b1;
						ctrl.regf.wr_addr_sel = cpu_ctrl_pkg::WR_ADDR_OLD_RB;
						ctrl.regf.wd_sel = cpu_ctrl_pkg::RDATA_IMM; // Second byte
						ctrl.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_ALU;
					end
					2'd1: begin // LDD
						ctrl.alu_op = cpu_ctrl_pkg::ALU_LDD;
						ctrl.mem.re = 1'b1;
						ctrl.mem.addr_sel = cpu_ctrl_pkg::DMEM_A_EA;
						ctrl.regf.we = 1'b1;
						ctrl.regf.wr_addr_sel = cpu_ctrl_pkg::WR_ADDR_OLD_RB;
						ctrl.regf.wd_sel = cpu_ctrl_pkg::RDATA_DATA;
						ctrl.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_MEM;
					end
					2'd2: begin // STD
						ctrl.alu_op = cpu_ctrl_pkg::ALU_STD;
						ctrl.mem.we = 1'b1;
						ctrl.mem.addr_sel = cpu_ctrl_pkg::DMEM_A_EA;
						ctrl.mem.wd_sel = cpu_ctrl_pkg::DMEM_WD_RB;
						ctrl.regf.rd2_sel = 1'b1; // Read port on held rb
					end
					default: begin
						ctrl = cpu_ctrl_pkg::CTRL_IDLE;
					end
				endcase
			end
			cpu_ctrl_pkg::SEQ_LOOP: begin
				// Decremented ra goes back
				ctrl.regf = cpu_ctrl_pkg::regf_alu_wb(cpu_ctrl_pkg::WR_ADDR_RA);
				ctrl.alu_op = cpu_ctrl_pkg::ALU_LOOP;
			end
			default: begin
				ctrl = cpu_ctrl_pkg::CTRL_IDLE;
			end
		endcase
	end

endmodule

// ==== testbench/control_unit_tb.sv ====
`timescale 1ns/1ps

module control_unit_tb;

	localparam int RESET_CYCLES = 10;

	typedef struct packed {
		cpu_ctrl_pkg::opcode_t  opcode;
		cpu_ctrl_pkg::flags_t   flags;
		logic                   rand_flags; // Flags from the xorshift source
		cpu_ctrl_pkg::ctrl_t    ctrl;
		cpu_ctrl_pkg::reg_idx_t old_rb;
		logic                   is_2byte_d;
	} row_t;

	logic                   clk;
	logic                   rst;
	cpu_ctrl_pkg::opcode_t  opcode;
	cpu_ctrl_pkg::flags_t   flags;
	cpu_ctrl_pkg::ctrl_t    ctrl;
	cpu_ctrl_pkg::reg_idx_t old_rb;
	logic                   is_2byte_d;
	logic                   two_byte;

	row_t                   rows[$];
	string                  names[$];
	cpu_ctrl_pkg::reg_idx_t cur_rb;       // rb of the last captured prefix
	logic [31:0]            rng;
	int                     cycle_count = 0;
	int                     cycle_limit = 0;

	tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (.clk(clk), .rst(rst));

	control_unit u_control_unit (
		.clk        (clk),
		.rst        (rst),
		.opcode     (opcode),
		.flags      (flags),
		.ctrl       (ctrl),
		.old_rb     (old_rb),
		.is_2byte_d (is_2byte_d),
		.two_byte   (two_byte)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic cpu_ctrl_pkg::ctrl_t op_only(input cpu_ctrl_pkg::alu_op_t op);
		cpu_ctrl_pkg::ctrl_t c;
		c = cpu_ctrl_pkg::CTRL_IDLE;
		c.alu_op = op;
		return c;
	endfunction

	function automatic cpu_ctrl_pkg::ctrl_t reg_write(input cpu_ctrl_pkg::alu_op_t op,
		input cpu_ctrl_pkg::wr_addr_sel_t dst, input cpu_ctrl_pkg::rdata_sel_t wd);
		cpu_ctrl_pkg::ctrl_t c;
		c = op_only(op);
		c.regf.we = 1'b1;
		c.regf.wr_addr_sel = dst;
		c.regf.wd_sel = wd;
		return c;
	endfunction

	// Result of the ALU written to dst
	function automatic cpu_ctrl_pkg::ctrl_t alu_write(input cpu_ctrl_pkg::alu_op_t op,
		input cpu_ctrl_pkg::wr_addr_sel_t dst);
		cpu_ctrl_pkg::ctrl_t c;
		c = reg_write(op, dst, cpu_ctrl_pkg::RDATA_DATA);
		c.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_ALU;
		return c;
	endfunction

	// pc loads the target passed through the ALU
	function automatic cpu_ctrl_pkg::ctrl_t jump_ctrl(input cpu_ctrl_pkg::alu_op_t op);
		cpu_ctrl_pkg::ctrl_t c;
		c = op_only(op);
		c.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_ALU;
		c.flow.pc_sel = cpu_ctrl_pkg::PC_SEL_JUMP;
		c.flow.branch_taken = 1'b1;
		return c;
	endfunction

	task automatic add_row(input string name, input cpu_ctrl_pkg::opcode_t op,
		input cpu_ctrl_pkg::flags_t f, input logic rnd, input cpu_ctrl_pkg::ctrl_t c,
		input logic two);
		row_t r;
		r = '{op, f, rnd, c, cur_rb, two};
		names.push_back(name);
		rows.push_back(r);
	endtask

	task automatic add_any(input string name, input cpu_ctrl_pkg::opcode_t op,
		input cpu_ctrl_pkg::ctrl_t c);
		add_row(name, op, 4'h0, 1'b1, c, 1'b0);
	endtask

	task automatic add_fixed(input string name, input cpu_ctrl_pkg::opcode_t op,
		input cpu_ctrl_pkg::flags_t f, input cpu_ctrl_pkg::ctrl_t c);
		add_row(name, op, f, 1'b0, c, 1'b0);
	endtask

	task automatic add_prefix(input string name, input cpu_ctrl_pkg::opcode_t op);
		add_row(name, op, 4'h0, 1'b1, cpu_ctrl_pkg::CTRL_IDLE, 1'b1);
		cur_rb = op[1:0]; // Held from the next row on
	endtask

	task automatic build_table();
		cpu_ctrl_pkg::ctrl_t e;
		add_any("nop_after_reset", 8'h00, cpu_ctrl_pkg::CTRL_IDLE);
		add_any("mov", 8'h16, alu_write(cpu_ctrl_pkg::ALU_MOV, cpu_ctrl_pkg::WR_ADDR_RA));
		add_any("add", 8'h2b, alu_write(cpu_ctrl_pkg::ALU_ADD, cpu_ctrl_pkg::WR_ADDR_RA));
		add_any("sub", 8'h39, alu_write(cpu_ctrl_pkg::ALU_SUB, cpu_ctrl_pkg::WR_ADDR_RA));
		add_any("and", 8'h47, alu_write(cpu_ctrl_pkg::ALU_AND, cpu_ctrl_pkg::WR_ADDR_RA));
		add_any("or", 8'h5e, alu_write(cpu_ctrl_pkg::ALU_OR, cpu_ctrl_pkg::WR_ADDR_RA));
		add_any("rlc", 8'h61, alu_write(cpu_ctrl_pkg::ALU_RLC, cpu_ctrl_pkg::WR_ADDR_RB));
		add_any("rrc", 8'h66, alu_write(cpu_ctrl_pkg::ALU_RRC, cpu_ctrl_pkg::WR_ADDR_RB));
		add_any("setc", 8'h6a, op_only(cpu_ctrl_pkg::ALU_SETC));
		add_any("clrc", 8'h6f, op_only(cpu_ctrl_pkg::ALU_CLRC));
		e = reg_write(cpu_ctrl_pkg::ALU_PUSH, cpu_ctrl_pkg::WR_ADDR_SP, cpu_ctrl_pkg::RDATA_STACK);
		e.mem = '{1'b1, 1'b0, cpu_ctrl_pkg::DMEM_A_SP, cpu_ctrl_pkg::DMEM_WD_RB}; // SP goes down
		add_any("push", 8'h71, e);
		e = reg_write(cpu_ctrl_pkg::ALU_POP, cpu_ctrl_pkg::WR_ADDR_RB, cpu_ctrl_pkg::RDATA_DATA);
		e.mem = '{1'b0, 1'b1, cpu_ctrl_pkg::DMEM_A_SP_INC, cpu_ctrl_pkg::DMEM_WD_ALU};
		e.flow.sp_dir = 1'b1;
		e.flow.sp_inc = 1'b1;
		add_any("pop", 8'h76, e);
		e = op_only(cpu_ctrl_pkg::ALU_OUT);
		e.flow.out_port = 1'b1;
		add_any("out", 8'h7a, e);
		add_any("in", 8'h7f, reg_write(cpu_ctrl_pkg::ALU_IN, cpu_ctrl_pkg::WR_ADDR_RB,
			cpu_ctrl_pkg::RDATA_IN_PORT));
		add_any("not", 8'h81, alu_write(cpu_ctrl_pkg::ALU_NOT, cpu_ctrl_pkg::WR_ADDR_RB));
		add_any("neg", 8'h86, alu_write(cpu_ctrl_pkg::ALU_NEG, cpu_ctrl_pkg::WR_ADDR_RB));
		add_any("inc", 8'h8a, alu_write(cpu_ctrl_pkg::ALU_INC, cpu_ctrl_pkg::WR_ADDR_RB));
		add_any("dec", 8'h8f, alu_write(cpu_ctrl_pkg::ALU_DEC, cpu_ctrl_pkg::WR_ADDR_RB));
		e = reg_write(cpu_ctrl_pkg::ALU_LDI, cpu_ctrl_pkg::WR_ADDR_RB, cpu_ctrl_pkg::RDATA_DATA);
		e.mem.re = 1'b1; // Address is ra through the ALU
		add_any("ldi", 8'hd3, e);
		e = op_only(cpu_ctrl_pkg::ALU_STI);
		e.mem = '{1'b1, 1'b0, cpu_ctrl_pkg::DMEM_A_ALU, cpu_ctrl_pkg::DMEM_WD_RB};
		add_any("sti", 8'he6, e);
		// Not-taken rows carry every other flag set
		add_fixed("jz_taken", 8'h91, 4'b0001, jump_ctrl(cpu_ctrl_pkg::ALU_PASS_RD2));
		add_fixed("jz_not_taken", 8'h91, 4'b1110, op_only(cpu_ctrl_pkg::ALU_JZ));
		add_fixed("jn_taken", 8'h95, 4'b0010, jump_ctrl(cpu_ctrl_pkg::ALU_PASS_RD2));
		add_fixed("jn_not_taken", 8'h95, 4'b1101, op_only(cpu_ctrl_pkg::ALU_JN));
		add_fixed("jc_taken", 8'h98, 4'b0100, jump_ctrl(cpu_ctrl_pkg::ALU_PASS_RD2));
		add_fixed("jc_not_taken", 8'h98, 4'b1011, op_only(cpu_ctrl_pkg::ALU_JC));
		add_fixed("jv_taken", 8'h9c, 4'b1000, jump_ctrl(cpu_ctrl_pkg::ALU_PASS_RD2));
		add_fixed("jv_not_taken", 8'h9c, 4'b0111, op_only(cpu_ctrl_pkg::ALU_JV));
		add_any("jmp", 8'hb2, jump_ctrl(cpu_ctrl_pkg::ALU_PASS_RD2));
		e = jump_ctrl(cpu_ctrl_pkg::ALU_CALL);
		e.regf.we = 1'b1;
		e.regf.wr_addr_sel = cpu_ctrl_pkg::WR_ADDR_SP;
		e.mem = '{1'b1, 1'b0, cpu_ctrl_pkg::DMEM_A_SP, cpu_ctrl_pkg::DMEM_WD_PC_INC};
		add_any("call", 8'hb5, e);
		e = op_only(cpu_ctrl_pkg::ALU_RET);
		e.mem = '{1'b0, 1'b1, cpu_ctrl_pkg::DMEM_A_SP, cpu_ctrl_pkg::DMEM_WD_ALU};
		e.flow = '{cpu_ctrl_pkg::PC_SEL_JUMP, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
		add_any("ret", 8'hb8, e);
		add_any("rti_dropped", 8'hbc, cpu_ctrl_pkg::CTRL_IDLE);
		e = op_only(cpu_ctrl_pkg::ALU_LOOP);
		e.flow.pc_sel = cpu_ctrl_pkg::PC_SEL_JUMP;
		e.flow.branch_taken = 1'b1;
		add_fixed("loop_z_clear", 8'ha4, 4'b1110, e);
		add_any("loop_z_clear_wb", 8'h71,
			alu_write(cpu_ctrl_pkg::ALU_LOOP, cpu_ctrl_pkg::WR_ADDR_RA));
		add_any("after_loop_add", 8'h2b,
			alu_write(cpu_ctrl_pkg::ALU_ADD, cpu_ctrl_pkg::WR_ADDR_RA));
		add_fixed("loop_z_set", 8'ha4, 4'b0001, op_only(cpu_ctrl_pkg::ALU_LOOP));
		add_any("loop_z_set_wb", 8'hc2,
			alu_write(cpu_ctrl_pkg::ALU_LOOP, cpu_ctrl_pkg::WR_ADDR_RA));
		add_any("after_loop_setc", 8'h6a, op_only(cpu_ctrl_pkg::ALU_SETC));
		add_prefix("ldm_first", 8'hc2);
		e = reg_write(cpu_ctrl_pkg::ALU_LDM, cpu_ctrl_pkg::WR_ADDR_OLD_RB,
			cpu_ctrl_pkg::RDATA_IMM);
		e.regf.out_sel = cpu_ctrl_pkg::OUT_SEL_ALU;
		add_any("ldm_second", 8'h26, e);
		add_prefix("ldd_first", 8'hc7);
		e = reg_write(cpu_ctrl_pkg::ALU_LDD, cpu_ctrl_pkg::WR_ADDR_OLD_RB,
			cpu_ctrl_pkg::RDATA_DATA);
		e.mem = '{1'b0, 1'b1, cpu_ctrl_pkg::DMEM_A_EA, cpu_ctrl_pkg::DMEM_WD_ALU};
		add_fixed("ldd_second", 8'h91, 4'b1111, e); // A JZ here would be taken
		add_prefix("std_first", 8'hc9);
		e = op_only(cpu_ctrl_pkg::ALU_STD);
		e.regf.rd2_sel = 1'b1;
		e.mem = '{1'b1, 1'b0, cpu_ctrl_pkg::DMEM_A_EA, cpu_ctrl_pkg::DMEM_WD_RB};
		add_any("std_second", 8'hc3, e); // Another prefix byte, ignored
		add_any("nop_end", 8'h00, cpu_ctrl_pkg::CTRL_IDLE);
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_ctrl(input string name, input cpu_ctrl_pkg::ctrl_t exp,
		input cpu_ctrl_pkg::ctrl_t act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch %s ctrl expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_reg_idx(input string name, input cpu_ctrl_pkg::reg_idx_t exp,
		input cpu_ctrl_pkg::reg_idx_t act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch %s old_rb expected %0d actual %0d", name, exp, act));
		end
	endtask

	// name carries the test and the output it looks at
	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			fail_run("timeout: the stimulus table did not complete within the cycle limit");
		end
	end

	initial begin
		opcode = '0;
		flags = '0;
		cur_rb = '0;
		rng = 32'd27;
		build_table();
		cycle_limit = RESET_CYCLES + rows.size() + 20;
		wait (rst === 1'b1);
		for (int i = 0; i < rows.size(); i++) begin
			@(negedge clk);
			opcode = rows[i].opcode;
			if (rows[i].rand_flags) begin
				rng = xorshift(rng);
				flags = rng[3:0];
			end else begin
				flags = rows[i].flags;
			end
			#1; // Mid low phase, before the state can change
			check_ctrl(names[i], rows[i].ctrl, ctrl);
			check_reg_idx(names[i], rows[i].old_rb, old_rb);
			check_flag({names[i], " is_2byte_d"}, rows[i].is_2byte_d, is_2byte_d);
			check_flag({names[i], " two_byte"}, rows[i].is_2byte_d, two_byte);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// Released on a falling edge, clear of the state register's edge
	initial begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b1;
	end

endmodule
